/* common/raytracer_pkg.sv */
// Shared Q16.16 types, scene layout constants and fixed-point math; imported by every RTL block
package raytracer_pkg;

    typedef logic signed [31:0] q16_t;
    typedef logic [7:0] color_t;

    typedef struct packed {
        q16_t x;
        q16_t y;
        q16_t z;
    } vec3_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } pixel_t;

    // Light and sphere share one layout so the register file can treat them alike
    typedef struct packed {
        vec3_t centre;
        q16_t  radius;
        rgb_t  colour;
    } sphere_t;

    typedef struct packed {
        vec3_t position;
        q16_t  intensity;
        rgb_t  colour;
    } light_t;

    typedef struct packed {
        logic       hit;
        q16_t       t;
        logic [7:0] sphere_idx;
        vec3_t      dir;
    } hit_rec_t;

    localparam q16_t Q16_ONE    = 32'sd65536;
    localparam int   SCREEN_CX  = 320;
    localparam int   SCREEN_CY  = 240;
    localparam q16_t FOCAL_Z    = 32'sd6553600;
    localparam rgb_t BG_COLOR   = '{r: 8'd0, g: 8'd0, b: 8'd32};

    localparam int APB_ADDR_W = 12;
    localparam logic [APB_ADDR_W-1:0] SPHERE_STRIDE = 12'h020;
    localparam logic [APB_ADDR_W-1:0] LIGHT_BASE    = 12'h200;

    function automatic q16_t q16_mul(input q16_t a, input q16_t b);
        logic signed [63:0] prod;
        prod = a * b;
        prod = prod + (Q16_ONE >>> 1);
        return prod[47:16];
    endfunction

    function automatic q16_t q16_div(input q16_t a, input q16_t b);
        logic signed [63:0] num;
        logic signed [63:0] quo;
        if (b == 32'sd0) begin
            return (a >= 32'sd0) ? 32'sh7FFF_FFFF : -32'sh7FFF_FFFF;
        end
        num = a;
        num = num <<< 16;
        quo = num / b;
        return quo[31:0];
    endfunction

    function automatic q16_t q16_dot3(input vec3_t a, input vec3_t b);
        logic signed [63:0] px;
        logic signed [63:0] py;
        logic signed [63:0] pz;
        px = (a.x * b.x) >>> 16;
        py = (a.y * b.y) >>> 16;
        pz = (a.z * b.z) >>> 16;
        return px[31:0] + py[31:0] + pz[31:0];
    endfunction

    // Digit-by-digit root of a << 16, so the result stays in Q16
    function automatic q16_t q16_sqrt(input q16_t a);
        logic [63:0] v;
        logic [63:0] rem;
        logic [63:0] root;
        if (a <= 32'sd0) begin
            return '0;
        end
        v = {32'd0, a} << 16;
        rem = '0;
        root = '0;
        for (int i = 23; i >= 0; i--) begin
            rem = (rem << 2) | ((v >> (2 * i)) & 64'd3);
            if (rem >= ((root << 2) | 64'd1)) begin
                rem = rem - ((root << 2) | 64'd1);
                root = (root << 1) | 64'd1;
            end else begin
                root = root << 1;
            end
        end
        return q16_t'(root[31:0]);
    endfunction

    function automatic vec3_t normalize3(input vec3_t v);
        q16_t  mag;
        vec3_t n;
        mag = q16_sqrt(q16_dot3(v, v));
        if (mag <= 32'sd0) begin
            return '0;
        end
        n.x = q16_div(v.x, mag);
        n.y = q16_div(v.y, mag);
        n.z = q16_div(v.z, mag);
        return n;
    endfunction

endpackage

/* design/scene_regs.sv */
// APB slave holding the sphere table and the point light; software loads the scene here
`timescale 1ns/1ps

module scene_regs import raytracer_pkg::*; #(
    parameter int NUM_SPHERES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [APB_ADDR_W-1:0]     paddr_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output sphere_t [NUM_SPHERES-1:0] spheres_o,
    output light_t                    light_o
);

    sphere_t [NUM_SPHERES-1:0] spheres_q;
    light_t                    light_q;

    logic [APB_ADDR_W-1:0] sph_idx;
    logic [APB_ADDR_W-1:0] off;
    logic                  is_sphere;
    logic                  is_light;
    logic                  mapped;
    sphere_t               rec;
    sphere_t               wr_rec;
    logic [31:0]           rdata;

    assign sph_idx   = paddr_i / SPHERE_STRIDE;
    assign off       = paddr_i % SPHERE_STRIDE;
    assign is_sphere = sph_idx < NUM_SPHERES;
    assign is_light  = (paddr_i >= LIGHT_BASE) && (paddr_i < LIGHT_BASE + SPHERE_STRIDE);
    assign mapped    = (is_sphere || is_light) && (off inside {12'h0, 12'h4, 12'h8, 12'hC, 12'h10});

    // Selected record is read and patched in one word, light viewed with the sphere layout
    always_comb begin
        rec = '0;
        if (is_light) begin
            rec = sphere_t'(light_q);
        end else if (is_sphere) begin
            rec = spheres_q[sph_idx];
        end
        wr_rec = rec;
        rdata  = '0;
        case (off)
            12'h0:  begin rdata = rec.centre.x;  wr_rec.centre.x = pwdata_i; end
            12'h4:  begin rdata = rec.centre.y;  wr_rec.centre.y = pwdata_i; end
            12'h8:  begin rdata = rec.centre.z;  wr_rec.centre.z = pwdata_i; end
            12'hC:  begin rdata = rec.radius;    wr_rec.radius   = pwdata_i; end
            12'h10: begin rdata = {8'h0, rec.colour}; wr_rec.colour = rgb_t'(pwdata_i[23:0]); end
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spheres_q <= '0;
            light_q   <= '0;
        end else if (psel_i && penable_i && pwrite_i && mapped) begin
            if (is_light) begin
                light_q <= light_t'(wr_rec);
            end else begin
                spheres_q[sph_idx] <= wr_rec;
            end
        end
    end

    assign prdata_o  = mapped ? rdata : 32'h0;
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i && penable_i && !mapped;
    assign spheres_o = spheres_q;
    assign light_o   = light_q;

endmodule

/* ray_engine/ray_gen.sv */
// Pinhole camera at the origin; maps a pixel coordinate to a unit primary ray direction
`timescale 1ns/1ps

module ray_gen import raytracer_pkg::*; (
    input  pixel_t pixel_i,
    output vec3_t  dir_o
);

    q16_t  off_x;
    q16_t  off_y;
    vec3_t raw;

    // Screen y grows downward, camera y points up
    assign off_x = q16_t'({22'd0, pixel_i.x}) - q16_t'(SCREEN_CX);
    assign off_y = q16_t'(SCREEN_CY) - q16_t'({23'd0, pixel_i.y});

    always_comb begin
        raw.x = off_x <<< 14;
        raw.y = off_y <<< 14;
        raw.z = FOCAL_Z;
    end

    assign dir_o = normalize3(raw);

endmodule

/* ray_engine/sphere_scan.sv */
// Iterative intersection FSM; tests one sphere per clock and hands the nearest hit to shading
`timescale 1ns/1ps

module sphere_scan import raytracer_pkg::*; #(
    parameter int NUM_SPHERES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      pixel_valid_i,
    output logic                      pixel_ready_o,
    input  vec3_t                     dir_i,
    input  sphere_t [NUM_SPHERES-1:0] spheres_i,
    output hit_rec_t                  hit_o,
    output logic                      hit_valid_o,
    input  logic                      shade_ready_i
);

    typedef enum logic [1:0] {IDLE, SCAN, HANDOFF} scan_state_e;

    scan_state_e state_q;
    logic [7:0]  idx_q;
    logic        best_hit_q;
    q16_t        best_t_q;
    logic [7:0]  best_idx_q;
    vec3_t       dir_q;

    logic        accept;
    logic        closer;
    sphere_t     sph;
    vec3_t       lvec;
    q16_t        a, half_b, c, disc, root, t0, t1, cand_t;
    logic        cand_hit;

    assign accept = pixel_valid_i && pixel_ready_o;

    // Ray origin is zero, so L = -centre
    always_comb begin
        sph    = spheres_i[idx_q];
        lvec.x = -sph.centre.x;
        lvec.y = -sph.centre.y;
        lvec.z = -sph.centre.z;
        a      = q16_dot3(dir_q, dir_q);
        half_b = q16_dot3(lvec, dir_q);
        c      = q16_dot3(lvec, lvec) - q16_mul(sph.radius, sph.radius);
        disc   = q16_mul(half_b, half_b) - q16_mul(a, c);
        root   = q16_sqrt(disc);
        t0     = q16_div(-half_b - root, a);
        t1     = q16_div(-half_b + root, a);
        cand_hit = 1'b0;
        cand_t   = '0;
        if (sph.radius != 32'sd0 && disc >= 32'sd0 && a != 32'sd0) begin
            if (t0 > 32'sd0 && (t1 <= 32'sd0 || t0 < t1)) begin
                cand_hit = 1'b1;
                cand_t   = t0;
            end else if (t1 > 32'sd0) begin
                cand_hit = 1'b1;
                cand_t   = t1;
            end
        end
        closer = cand_hit && (!best_hit_q || cand_t < best_t_q);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            idx_q      <= '0;
            best_hit_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (accept) begin
                    state_q    <= SCAN;
                    idx_q      <= '0;
                    best_hit_q <= 1'b0;
                end
                SCAN: begin
                    if (closer) best_hit_q <= 1'b1;
                    if (idx_q == 8'(NUM_SPHERES - 1)) state_q <= HANDOFF;
                    else idx_q <= idx_q + 8'd1;
                end
                HANDOFF: if (shade_ready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) dir_q <= dir_i;
        if (state_q == SCAN && closer) begin
            best_t_q   <= cand_t;
            best_idx_q <= idx_q;
        end
    end

    assign pixel_ready_o = (state_q == IDLE);
    assign hit_valid_o   = (state_q == HANDOFF);
    assign hit_o = '{hit: best_hit_q, t: best_t_q, sphere_idx: best_idx_q, dir: dir_q};

endmodule

/* ray_engine/shade_unit.sv */
// One-entry shading stage; ambient plus Lambert diffuse from the point light, held under back-pressure
`timescale 1ns/1ps

module shade_unit import raytracer_pkg::*; #(
    parameter int NUM_SPHERES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  hit_rec_t                  hit_i,
    input  logic                      hit_valid_i,
    output logic                      shade_ready_o,
    input  sphere_t [NUM_SPHERES-1:0] spheres_i,
    input  light_t                    light_i,
    output rgb_t                      rgb_o,
    output logic                      rgb_valid_o,
    input  logic                      rgb_ready_i
);

    // Ambient is base/8, diffuse scales base*light/256 by dif/16
    function automatic color_t shade_chan(input color_t base, input color_t lite,
                                          input logic [4:0] dif);
        logic [15:0] mix;
        logic [12:0] scaled;
        logic [8:0]  sum;
        mix    = base * lite;
        scaled = mix[15:8] * dif;
        sum    = 9'(base >> 3) + 9'(scaled >> 4);
        return (sum > 9'd255) ? 8'd255 : sum[7:0];
    endfunction

    hit_rec_t   rec_q;
    logic       valid_q;
    sphere_t    sph;
    vec3_t      point, n_raw, to_light;
    q16_t       ndotl, dif_raw;
    logic [4:0] dif;
    rgb_t       lit;

    assign shade_ready_o = !valid_q || rgb_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) valid_q <= 1'b0;
        else if (shade_ready_o) valid_q <= hit_valid_i;
    end

    always_ff @(posedge clk) begin
        if (hit_valid_i && shade_ready_o) rec_q <= hit_i;
    end

    always_comb begin
        sph        = spheres_i[rec_q.sphere_idx];
        point.x    = q16_mul(rec_q.t, rec_q.dir.x);
        point.y    = q16_mul(rec_q.t, rec_q.dir.y);
        point.z    = q16_mul(rec_q.t, rec_q.dir.z);
        n_raw.x    = point.x - sph.centre.x;
        n_raw.y    = point.y - sph.centre.y;
        n_raw.z    = point.z - sph.centre.z;
        to_light.x = light_i.position.x - point.x;
        to_light.y = light_i.position.y - point.y;
        to_light.z = light_i.position.z - point.z;
        ndotl      = q16_dot3(normalize3(n_raw), normalize3(to_light));
        dif_raw    = q16_mul(ndotl, light_i.intensity) >>> 12;
        if (dif_raw < 32'sd0) dif = 5'd0;
        else if (dif_raw > 32'sd16) dif = 5'd16;
        else dif = dif_raw[4:0];
        lit.r = shade_chan(sph.colour.r, light_i.colour.r, dif);
        lit.g = shade_chan(sph.colour.g, light_i.colour.g, dif);
        lit.b = shade_chan(sph.colour.b, light_i.colour.b, dif);
    end

    assign rgb_o       = rec_q.hit ? lit : BG_COLOR;
    assign rgb_valid_o = valid_q;

endmodule

/* design/raytracer_top.sv */
// Ray caster top level; APB scene registers feeding the ray generator, sphere scan and shading
`timescale 1ns/1ps

module raytracer_top import raytracer_pkg::*; #(
    parameter int NUM_SPHERES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  pixel_t                pixel_i,
    input  logic                  pixel_valid_i,
    output logic                  pixel_ready_o,
    output rgb_t                  rgb_o,
    output logic                  rgb_valid_o,
    input  logic                  rgb_ready_i
);

    sphere_t [NUM_SPHERES-1:0] spheres;
    light_t                    light;
    vec3_t                     dir;
    hit_rec_t                  hit;
    logic                      hit_valid;
    logic                      shade_ready;

    scene_regs #(.NUM_SPHERES(NUM_SPHERES)) u_scene_regs (
        .clk, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o, .spheres_o(spheres), .light_o(light)
    );

    ray_gen u_ray_gen (.pixel_i, .dir_o(dir));

    sphere_scan #(.NUM_SPHERES(NUM_SPHERES)) u_sphere_scan (
        .clk, .rst_n_i, .pixel_valid_i, .pixel_ready_o, .dir_i(dir),
        .spheres_i(spheres), .hit_o(hit), .hit_valid_o(hit_valid),
        .shade_ready_i(shade_ready)
    );

    shade_unit #(.NUM_SPHERES(NUM_SPHERES)) u_shade_unit (
        .clk, .rst_n_i, .hit_i(hit), .hit_valid_i(hit_valid),
        .shade_ready_o(shade_ready), .spheres_i(spheres), .light_i(light),
        .rgb_o, .rgb_valid_o, .rgb_ready_i
    );

endmodule

/* testbench/raytracer_assertions.sv */
// Concurrent checks on the ray caster handshakes, latency and reset state; bound to raytracer_top
`timescale 1ns/1ps

module raytracer_assertions import raytracer_pkg::*; #(
    parameter int NUM_SPHERES = 4
) (
    input logic clk,
    input logic rst_n_i,
    input logic pixel_valid_i,
    input logic pixel_ready_o,
    input rgb_t rgb_o,
    input logic rgb_valid_o,
    input logic rgb_ready_i,
    input logic pslverr_o
);

    localparam int LAT = NUM_SPHERES + 2;

    logic           accept;
    logic           taken;
    logic [LAT-1:0] accept_hist;
    int             ready_run;
    int             in_flight;

    assign accept = pixel_valid_i && pixel_ready_o;
    assign taken  = rgb_valid_o && rgb_ready_i;

    // Accept history and the length of the current run of sink-ready cycles
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            accept_hist <= '0;
            ready_run   <= 0;
            in_flight   <= 0;
        end else begin
            accept_hist <= {accept_hist[LAT-2:0], accept};
            ready_run   <= !rgb_ready_i ? 0 : (ready_run < LAT) ? ready_run + 1 : ready_run;
            in_flight   <= in_flight + int'(accept) - int'(taken);
        end
    end

    hold_colour: assert property (@(posedge clk) disable iff (!rst_n_i)
        rgb_valid_o && !rgb_ready_i |=> rgb_valid_o && $stable(rgb_o))
        else $error("rgb_o or rgb_valid_o changed while the sink stalled");

    // Scan of NUM_SPHERES cycles, one handoff edge, then the registered colour
    latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept_hist[LAT-1] && ready_run >= LAT - 1 |-> rgb_valid_o && !$past(rgb_valid_o))
        else $error("rgb_valid_o did not rise NUM_SPHERES + 2 edges after acceptance");

    reset_state: assert property (@(posedge clk)
        !rst_n_i |-> pixel_ready_o && !rgb_valid_o && !pslverr_o)
        else $error("outputs not at their reset values during reset");

    balance: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_flight >= 0 && in_flight <= 2)
        else $error("colour outputs do not match accepted pixels");

endmodule

/* testbench/raytracer_tb.sv */
// Testbench for the ray caster; loads scenes over APB, streams pixels and checks every colour
`timescale 1ns/1ps

module raytracer_tb import raytracer_pkg::*; ();

    localparam int NUM_SPHERES = 4;
    localparam int NUM_PIX     = 200;
    localparam int CYCLE_LIMIT = 20000;
    localparam logic [23:0] BG_RGB = 24'h000020;

    typedef enum logic [1:0] {MODE_BG, MODE_FLAT, MODE_LIT} check_mode_e;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [31:0]           pwdata_i;
    logic [31:0]           prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    pixel_t                pixel_i;
    logic                  pixel_valid_i;
    logic                  pixel_ready_o;
    rgb_t                  rgb_o;
    logic                  rgb_valid_o;
    logic                  rgb_ready_i;

    pixel_t      pix_list [NUM_PIX];
    pixel_t      sent_q [$];
    check_mode_e mode;
    rgb_t        base_rgb;
    logic        gaps;
    int          seed = 67316;
    int          accepted;
    int          received;
    int          cycles;

    raytracer_top #(.NUM_SPHERES(NUM_SPHERES)) UUT (.*);

    bind raytracer_top raytracer_assertions #(.NUM_SPHERES(NUM_SPHERES)) u_assertions (
        .clk(clk), .rst_n_i(rst_n_i), .pixel_valid_i(pixel_valid_i),
        .pixel_ready_o(pixel_ready_o), .rgb_o(rgb_o), .rgb_valid_o(rgb_valid_o),
        .rgb_ready_i(rgb_ready_i), .pslverr_o(pslverr_o)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d colours seen",
                     cycles, received, accepted);
            abort_run();
        end
    end

    // Sink ready with random stalls in some scenes
    always @(posedge clk) begin
        #2 rgb_ready_i = !gaps || ($random(seed) % 3 != 0);
    end

    function automatic color_t ceil_chan(input color_t c);
        return (c + (c >> 3) > 255) ? 8'd255 : 8'(c + (c >> 3));
    endfunction

    task automatic check_colour(input pixel_t p, input rgb_t got);
        int   dx;
        int   dy;
        rgb_t lo;
        rgb_t hi;
        rgb_t exp;
        logic lit_ok;
        logic ok;
        dx = int'(p.x) - 320;
        dy = int'(p.y) - 240;
        lo = '{base_rgb.r >> 3, base_rgb.g >> 3, base_rgb.b >> 3};
        hi = '{ceil_chan(base_rgb.r), ceil_chan(base_rgb.g), ceil_chan(base_rgb.b)};
        if (mode != MODE_LIT) begin
            exp = (mode == MODE_BG) ? rgb_t'(BG_RGB) : lo;
            assert (got == exp) else begin
                $display("** Error at %0d ns: rgb_o for pixel (%0d,%0d) expected %h, got %h",
                         $time, p.x, p.y, exp, got);
                abort_run();
            end
        end else begin
            lit_ok = got.r >= lo.r && got.r <= hi.r && got.g >= lo.g && got.g <= hi.g
                     && got.b >= lo.b && got.b <= hi.b;
            // Sphere edge lies near radius 103 px and the band around it may go either way
            if (dx * dx + dy * dy < 6400) ok = lit_ok;
            else if (dx * dx + dy * dy > 16900) ok = (got == BG_RGB);
            else ok = lit_ok || got == BG_RGB;
            assert (ok) else begin
                $display("** Error at %0d ns: rgb_o at (%0d,%0d) expected %h..%h or %h, got %h",
                         $time, p.x, p.y, lo, hi, BG_RGB, got);
                abort_run();
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n_i && rgb_valid_o && rgb_ready_i) begin
            assert (sent_q.size() > 0) else begin
                $display("A colour came out with no pixel outstanding");
                abort_run();
            end
            check_colour(sent_q.pop_front(), rgb_o);
            received++;
        end
    end

    // One APB transfer started 2 ns after an edge
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #2 penable_i = 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        assert (pready_o === 1'b1) else begin
            $display("** Error at %0d ns: pready_o at %h expected 1, got %b",
                     $time, addr, pready_o);
            abort_run();
        end
        @(posedge clk);
        #2 psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        assert (err == exp_err) else begin
            $display("** Error at %0d ns: pslverr_o on write to %h expected %b, got %b",
                     $time, addr, exp_err, err);
            abort_run();
        end
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rd, err);
        assert (err == exp_err && (exp_err || rd == exp)) else begin
            $display("** Error at %0d ns: prdata_o/pslverr_o at %h expected %h/%b, got %h/%b",
                     $time, addr, exp, exp_err, rd, err);
            abort_run();
        end
    endtask

    task automatic reg_roundtrip(input logic [11:0] addr, input logic [31:0] data,
                                 input logic [31:0] exp);
        apb_write(addr, data, 1'b0);
        apb_read(addr, exp, 1'b0);
    endtask

    task automatic load_record(input logic [11:0] base, input q16_t x, input q16_t y,
                               input q16_t z, input q16_t r, input logic [23:0] col);
        apb_write(base, x, 1'b0);
        apb_write(base + 12'h4, y, 1'b0);
        apb_write(base + 12'h8, z, 1'b0);
        apb_write(base + 12'hC, r, 1'b0);
        apb_write(base + 12'h10, {8'h0, col}, 1'b0);
    endtask

    // Offers pixels from the list in order, then waits until every colour is back
    task automatic stream_pixels(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            pixel_i       = pix_list[i];
            pixel_valid_i = 1'b1;
            do @(negedge clk); while (!pixel_ready_o);
            @(posedge clk);
            sent_q.push_back(pix_list[i]);
            accepted++;
            #2 pixel_valid_i = 1'b0;
        end
        wait (received == accepted);
        @(posedge clk);
        #2;
    endtask

    initial begin
        rst_n_i       = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        rgb_ready_i   = 1'b0;
        gaps          = 1'b0;
        mode          = MODE_BG;
        base_rgb      = '0;
        // Full screen first, then a window around the centre for the lit sphere
        for (int i = 0; i < NUM_PIX; i++) begin
            if (i < 120) begin
                pix_list[i].x = 10'($unsigned($random(seed)) % 640);
                pix_list[i].y = 9'($unsigned($random(seed)) % 480);
            end else begin
                pix_list[i].x = 10'(160 + $unsigned($random(seed)) % 320);
                pix_list[i].y = 9'(80 + $unsigned($random(seed)) % 320);
            end
        end
        repeat (16) @(posedge clk);
        #2 rst_n_i = 1'b1;

        reg_roundtrip(12'h060, 32'h1234_5678, 32'h1234_5678);
        reg_roundtrip(12'h064, 32'hFFFF_0000, 32'hFFFF_0000);
        reg_roundtrip(12'h06C, 32'h0001_8000, 32'h0001_8000);
        reg_roundtrip(12'h070, 32'hABC0_FFEE, 32'h00C0_FFEE);
        reg_roundtrip(12'h208, 32'h8000_0001, 32'h8000_0001);
        reg_roundtrip(12'h20C, 32'h0003_0000, 32'h0003_0000);
        reg_roundtrip(12'h210, 32'hFF12_3456, 32'h0012_3456);
        apb_write(12'h074, 32'hDEAD_BEEF, 1'b1);
        apb_read(12'h074, 32'h0, 1'b1);
        apb_write(12'h080, 32'hDEAD_BEEF, 1'b1);
        apb_write(12'h230, 32'hDEAD_BEEF, 1'b1);
        apb_read(12'h060, 32'h1234_5678, 1'b0);
        apb_read(12'h064, 32'hFFFF_0000, 1'b0);
        apb_read(12'h070, 32'h00C0_FFEE, 1'b0);
        apb_read(12'h000, 32'h0, 1'b0);
        apb_read(12'h210, 32'h0012_3456, 1'b0);
        // Back to an empty, unlit scene
        reg_roundtrip(12'h06C, 32'h0, 32'h0);
        reg_roundtrip(12'h20C, 32'h0, 32'h0);

        mode = MODE_BG;
        stream_pixels(0, 40);

        // Camera inside a sphere with the light off
        load_record(12'h000, 32'h0, 32'h0, 32'h0, 32'h0064_0000, 24'hC87830);
        mode     = MODE_FLAT;
        base_rgb = 24'hC87830;
        gaps     = 1'b1;
        stream_pixels(40, 40);

        load_record(12'h020, 32'h0, 32'h0, 32'h0, 32'h0032_0000, 24'h40A0F8);
        base_rgb = 24'h40A0F8;
        gaps     = 1'b0;
        stream_pixels(80, 40);

        // Sphere 120 ahead with radius 30 and a white light beside the camera
        load_record(12'h000, 32'h0, 32'h0, 32'h0078_0000, 32'h001E_0000, 24'hC86428);
        load_record(12'h020, 32'h0, 32'h0, 32'h0, 32'h0, 24'h0);
        load_record(LIGHT_BASE, 32'h000A_0000, 32'h000A_0000, 32'h0, 32'h0001_0000, 24'hFFFFFF);
        mode     = MODE_LIT;
        base_rgb = 24'hC86428;
        gaps     = 1'b1;
        stream_pixels(120, 80);

        if (received == accepted && sent_q.size() == 0 && accepted == NUM_PIX) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("** Error at %0d ns: colours received expected %0d, got %0d",
                     $time, accepted, received);
            abort_run();
        end
    end

endmodule

/* raytracer.f */
common/raytracer_pkg.sv
design/scene_regs.sv
ray_engine/ray_gen.sv
ray_engine/sphere_scan.sv
ray_engine/shade_unit.sv
design/raytracer_top.sv
testbench/raytracer_assertions.sv
testbench/raytracer_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = raytracer_tb
FILELIST  = raytracer.f

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: simulate clean
